// ==== source/idu_pkg.sv ====
`default_nettype none

package idu_pkg;

    parameter int XLEN = 32;

    // ========================================
    // encodings
    // ========================================

    // major opcodes, bits [6:0] of the instruction
    typedef enum logic [6:0] {
        opc_op_imm = 7'b0010011,
        opc_op     = 7'b0110011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_branch = 7'b1100011,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_system = 7'b1110011
    } rv_opcode_e;

    // pass forwards operand 2 unchanged
    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_slt, alu_sltu, alu_xor, alu_or,
        alu_and, alu_sll, alu_srl, alu_sra, alu_pass
    } alu_op_e;

    typedef enum logic {src1_rs1, src1_pc} alu_src1_e;

    typedef enum logic [1:0] {src2_rs2, src2_imm, src2_four, src2_csr} alu_src2_e;

    typedef enum logic [2:0] {
        fmt_r, fmt_i, fmt_s, fmt_b, fmt_u, fmt_j, fmt_none
    } inst_fmt_e;

    // follows the load/store func3 encoding
    typedef enum logic [2:0] {
        mem_byte   = 3'b000,
        mem_half   = 3'b001,
        mem_word   = 3'b010,
        mem_byte_u = 3'b100,
        mem_half_u = 3'b101,
        mem_none   = 3'b111
    } mem_size_e;

    // base of the jump target
    typedef enum logic [1:0] {jmp_none, jmp_pc_imm, jmp_rs1_imm, jmp_csr} jump_kind_e;

    // ========================================
    // bundles
    // ========================================

    typedef struct packed {
        alu_op_e    alu_op;
        alu_src1_e  src1;
        alu_src2_e  src2;
        inst_fmt_e  fmt;
        jump_kind_e jump_kind;
        logic       is_branch;
        logic       write_gpr;
        logic       write_csr;
        logic       mem_to_reg;
        logic       write_mem;
        mem_size_e  mem_size;
        logic [11:0] csr_id;
        logic       halt;
        logic       illegal;
    } decode_ctrl_t;

    typedef struct packed {
        decode_ctrl_t    ctrl;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] imm;
        logic [XLEN-1:0] rs1_data;
        logic [XLEN-1:0] rs2_data;
        logic [4:0]      rd;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
    } decode_out_t;

    // writeback port into the register file
    typedef struct packed {
        logic            en;
        logic [4:0]      addr;
        logic [XLEN-1:0] data;
    } gpr_wb_t;

endpackage

`default_nettype wire

// ==== source/idu_decode.sv ====
`default_nettype none

module idu_decode import idu_pkg::*; #(
    parameter int NUM_GPR = 16
) (
    input  wire logic [XLEN-1:0] inst_i,
    output decode_ctrl_t         ctrl_o,
    output logic [4:0]           rd_o,
    output logic [4:0]           rs1_o,
    output logic [4:0]           rs2_o
);

    rv_opcode_e opcode;
    logic [2:0] func3;
    logic [6:0] func7;
    logic       bad_enc;
    logic       reg_bad;
    logic       use_rd;
    logic       use_rs1;
    logic       use_rs2;

    // register index outside the implemented file
    function automatic logic idx_bad(input logic [4:0] idx);
        return int'(idx) >= NUM_GPR;
    endfunction

    assign opcode = rv_opcode_e'(inst_i[6:0]);
    assign rd_o   = inst_i[11:7];
    assign func3  = inst_i[14:12];
    assign rs1_o  = inst_i[19:15];
    assign rs2_o  = inst_i[24:20];
    assign func7  = inst_i[31:25];

    always_comb begin
        ctrl_o           = '0;
        ctrl_o.alu_op    = alu_add;
        ctrl_o.src1      = src1_rs1;
        ctrl_o.src2      = src2_imm;
        ctrl_o.fmt       = fmt_none;
        ctrl_o.jump_kind = jmp_none;
        ctrl_o.mem_size  = mem_none;
        bad_enc          = 1'b0;
        use_rd           = 1'b0;
        use_rs1          = 1'b0;
        use_rs2          = 1'b0;

        // ========================================
        // opcode groups
        // ========================================
        case (opcode)
            opc_op_imm: begin
                ctrl_o.fmt       = fmt_i;
                ctrl_o.write_gpr = 1'b1;
                use_rd           = 1'b1;
                use_rs1          = 1'b1;
                case (func3)
                    3'b000: ctrl_o.alu_op = alu_add;
                    3'b010: ctrl_o.alu_op = alu_slt;
                    3'b011: ctrl_o.alu_op = alu_sltu;
                    3'b100: ctrl_o.alu_op = alu_xor;
                    3'b110: ctrl_o.alu_op = alu_or;
                    3'b111: ctrl_o.alu_op = alu_and;
                    3'b001: begin
                        ctrl_o.alu_op = alu_sll;
                        bad_enc       = (func7 != 7'b0000000);
                    end
                    default: begin
                        // func3 101, shift right by shamt
                        ctrl_o.alu_op = (func7[5]) ? alu_sra : alu_srl;
                        bad_enc       = ({func7[6], func7[4:0]} != 6'b000000);
                    end
                endcase
            end
            opc_op: begin
                ctrl_o.fmt       = fmt_r;
                ctrl_o.src2      = src2_rs2;
                ctrl_o.write_gpr = 1'b1;
                use_rd           = 1'b1;
                use_rs1          = 1'b1;
                use_rs2          = 1'b1;
                case ({func7, func3})
                    10'b0000000_000: ctrl_o.alu_op = alu_add;
                    10'b0100000_000: ctrl_o.alu_op = alu_sub;
                    10'b0000000_001: ctrl_o.alu_op = alu_sll;
                    10'b0000000_010: ctrl_o.alu_op = alu_slt;
                    10'b0000000_011: ctrl_o.alu_op = alu_sltu;
                    10'b0000000_100: ctrl_o.alu_op = alu_xor;
                    10'b0000000_101: ctrl_o.alu_op = alu_srl;
                    10'b0100000_101: ctrl_o.alu_op = alu_sra;
                    10'b0000000_110: ctrl_o.alu_op = alu_or;
                    10'b0000000_111: ctrl_o.alu_op = alu_and;
                    default:         bad_enc       = 1'b1;
                endcase
            end
            opc_load: begin
                ctrl_o.fmt        = fmt_i;
                ctrl_o.write_gpr  = 1'b1;
                ctrl_o.mem_to_reg = 1'b1;
                ctrl_o.mem_size   = mem_size_e'(func3);
                use_rd            = 1'b1;
                use_rs1           = 1'b1;
                bad_enc           = (func3 == 3'b011) || (func3 > 3'b101);
            end
            opc_store: begin
                ctrl_o.fmt       = fmt_s;
                ctrl_o.write_mem = 1'b1;
                ctrl_o.mem_size  = mem_size_e'(func3);
                use_rs1          = 1'b1;
                use_rs2          = 1'b1;
                bad_enc          = (func3 > 3'b010);
            end
            opc_branch: begin
                ctrl_o.fmt       = fmt_b;
                ctrl_o.src2      = src2_rs2;
                ctrl_o.is_branch = 1'b1;
                use_rs1          = 1'b1;
                use_rs2          = 1'b1;
                // unsigned compares for bltu and bgeu
                ctrl_o.alu_op    = (func3[2:1] == 2'b11) ? alu_sltu : alu_slt;
                bad_enc          = (func3[2:1] == 2'b01);
            end
            opc_jal: begin
                ctrl_o.fmt       = fmt_j;
                ctrl_o.src1      = src1_pc;
                ctrl_o.src2      = src2_four;
                ctrl_o.jump_kind = jmp_pc_imm;
                ctrl_o.write_gpr = 1'b1;
                use_rd           = 1'b1;
            end
            opc_jalr: begin
                ctrl_o.fmt       = fmt_i;
                ctrl_o.src2      = src2_four;
                ctrl_o.jump_kind = jmp_rs1_imm;
                ctrl_o.write_gpr = 1'b1;
                use_rd           = 1'b1;
                use_rs1          = 1'b1;
                bad_enc          = (func3 != 3'b000);
            end
            opc_lui: begin
                ctrl_o.fmt       = fmt_u;
                ctrl_o.alu_op    = alu_pass;
                ctrl_o.write_gpr = 1'b1;
                use_rd           = 1'b1;
            end
            opc_auipc: begin
                ctrl_o.fmt       = fmt_u;
                ctrl_o.src1      = src1_pc;
                ctrl_o.write_gpr = 1'b1;
                use_rd           = 1'b1;
            end
            opc_system: begin
                ctrl_o.csr_id = inst_i[31:20];
                case (func3)
                    3'b000: begin
                        // ecall, ebreak and mret carry zero rd and rs1
                        bad_enc = (rd_o != 5'd0) || (rs1_o != 5'd0);
                        case (inst_i[31:20])
                            12'h000: begin
                                ctrl_o.fmt       = fmt_i;
                                ctrl_o.jump_kind = jmp_csr;
                                ctrl_o.write_csr = 1'b1;
                            end
                            12'h001: begin
                                ctrl_o.fmt  = fmt_i;
                                ctrl_o.halt = 1'b1;
                            end
                            12'h302: begin
                                ctrl_o.fmt       = fmt_r;
                                ctrl_o.jump_kind = jmp_csr;
                            end
                            default: bad_enc = 1'b1;
                        endcase
                    end
                    3'b001, 3'b010: begin
                        // csrrw and csrrs, old csr value goes to rd
                        ctrl_o.fmt       = fmt_i;
                        ctrl_o.alu_op    = alu_pass;
                        ctrl_o.src2      = src2_csr;
                        ctrl_o.write_gpr = 1'b1;
                        ctrl_o.write_csr = 1'b1;
                        use_rd           = 1'b1;
                        use_rs1          = 1'b1;
                    end
                    default: bad_enc = 1'b1;
                endcase
            end
            default: bad_enc = 1'b1;
        endcase

        // ========================================
        // illegal instructions have no side effects
        // ========================================
        reg_bad = (use_rd && idx_bad(rd_o)) || (use_rs1 && idx_bad(rs1_o)) ||
                  (use_rs2 && idx_bad(rs2_o));
        ctrl_o.illegal = bad_enc || reg_bad;
        if (ctrl_o.illegal) begin
            ctrl_o.write_gpr  = 1'b0;
            ctrl_o.write_csr  = 1'b0;
            ctrl_o.mem_to_reg = 1'b0;
            ctrl_o.write_mem  = 1'b0;
            ctrl_o.is_branch  = 1'b0;
            ctrl_o.halt       = 1'b0;
            ctrl_o.jump_kind  = jmp_none;
        end
        if (bad_enc) begin
            ctrl_o.fmt      = fmt_none;
            ctrl_o.mem_size = mem_none;
        end
    end

endmodule

`default_nettype wire

// ==== source/idu_imm_gen.sv ====
`default_nettype none

module idu_imm_gen import idu_pkg::*; (
    input  wire logic [XLEN-1:0] inst_i,
    input  wire inst_fmt_e       fmt_i,
    output logic [XLEN-1:0]      imm_o
);

    logic sign;

    assign sign = inst_i[31];

    // ========================================
    // immediate assembly per format
    // ========================================
    always_comb begin
        case (fmt_i)
            idu_pkg::fmt_i: begin
                imm_o = {{20{sign}}, inst_i[31:20]};
            end
            fmt_s: begin
                // split field, upper bits above rs2
                imm_o = {{20{sign}}, inst_i[31:25], inst_i[11:7]};
            end
            fmt_b: begin
                imm_o = {{19{sign}}, sign, inst_i[7], inst_i[30:25],
                         inst_i[11:8], 1'b0};
            end
            fmt_u: begin
                imm_o = {inst_i[31:12], 12'b0};
            end
            fmt_j: begin
                imm_o = {{11{sign}}, sign, inst_i[19:12], inst_i[20],
                         inst_i[30:21], 1'b0};
            end
            default: begin
                // r-type and unknown formats
                imm_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== source/idu_gpr_file.sv ====
`default_nettype none

module idu_gpr_file import idu_pkg::*; #(
    parameter int NUM_GPR = 16
) (
    input  wire logic       clk_i,
    input  wire logic       rst_n_i,
    input  wire logic [4:0] rs1_addr_i,
    input  wire logic [4:0] rs2_addr_i,
    input  wire gpr_wb_t    wb_i,
    output logic [XLEN-1:0] rs1_data_o,
    output logic [XLEN-1:0] rs2_data_o
);

    localparam int AW = $clog2(NUM_GPR);

    // x0 has no storage
    logic [XLEN-1:0] regs_q [1:NUM_GPR-1];
    logic            wr_en;

    assign wr_en = wb_i.en && (wb_i.addr != 5'd0) && (int'(wb_i.addr) < NUM_GPR);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < NUM_GPR; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en) begin
            regs_q[wb_i.addr[AW-1:0]] <= wb_i.data;
        end
    end

    // read with bypass of a same-cycle write
    function automatic logic [XLEN-1:0] read_port(input logic [4:0] addr);
        logic [XLEN-1:0] data;
        data = '0;
        if ((addr != 5'd0) && (int'(addr) < NUM_GPR)) begin
            if (wr_en && (wb_i.addr == addr)) begin
                data = wb_i.data;
            end else begin
                data = regs_q[addr[AW-1:0]];
            end
        end
        return data;
    endfunction

    always_comb begin
        rs1_data_o = read_port(rs1_addr_i);
        rs2_data_o = read_port(rs2_addr_i);
    end

endmodule

`default_nettype wire

// ==== source/idu_top.sv ====
`default_nettype none

module idu_top import idu_pkg::*; #(
    parameter int NUM_GPR = 16
) (
    input  wire logic            clk_i,
    input  wire logic            rst_n_i,
    input  wire logic            inst_valid_i,
    input  wire logic [XLEN-1:0] inst_i,
    input  wire logic [XLEN-1:0] pc_i,
    input  wire logic            stall_i,
    input  wire gpr_wb_t         wb_i,
    output logic                 dec_valid_o,
    output decode_out_t          dec_o
);

    decode_ctrl_t    ctrl;
    logic [4:0]      rd;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    decode_out_t     dec_next;

    // ========================================
    // combinational decode
    // ========================================
    idu_decode #(
        .NUM_GPR (NUM_GPR)
    ) decode_i (
        .inst_i (inst_i),
        .ctrl_o (ctrl),
        .rd_o   (rd),
        .rs1_o  (rs1),
        .rs2_o  (rs2)
    );

    idu_imm_gen imm_gen_i (
        .inst_i (inst_i),
        .fmt_i  (ctrl.fmt),
        .imm_o  (imm)
    );

    idu_gpr_file #(
        .NUM_GPR (NUM_GPR)
    ) gpr_file_i (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .rs1_addr_i (rs1),
        .rs2_addr_i (rs2),
        .wb_i       (wb_i),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    assign dec_next = '{ctrl: ctrl, pc: pc_i, imm: imm, rs1_data: rs1_data,
                        rs2_data: rs2_data, rd: rd, rs1: rs1, rs2: rs2};

    // ========================================
    // decode/execute stage register
    // ========================================
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            dec_valid_o <= 1'b0;
            dec_o       <= '0;
        end else if (!stall_i) begin
            // stall holds both valid and bundle
            dec_valid_o <= inst_valid_i;
            dec_o       <= dec_next;
        end
    end

endmodule

`default_nettype wire

// ==== dv/idu_chk.sv ====
`default_nettype none

module idu_chk import idu_pkg::*; (
    input  wire logic        clk_i,
    input  wire logic        rst_n_i,
    input  wire logic        stall_i,
    input  wire logic        dec_valid_o,
    input  wire decode_out_t dec_o
);

    int fail_count = 0;

    // first edge out of reset still sees an empty stage
    a_reset_valid: assert property (@(posedge clk_i) $rose(rst_n_i) |-> !dec_valid_o)
        else begin
            fail_count++;
            $error("dec_valid_o high on the first edge after reset");
        end

    a_stall_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        stall_i |=> $stable(dec_o) && $stable(dec_valid_o))
        else begin
            fail_count++;
            $error("stage register changed while stall_i was high");
        end

    // a legal instruction always has a format
    a_fmt_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        dec_valid_o && !dec_o.ctrl.illegal |-> dec_o.ctrl.fmt != fmt_none)
        else begin
            fail_count++;
            $error("legal instruction decoded with format none");
        end

    a_store_size: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        dec_o.ctrl.write_mem |-> dec_o.ctrl.mem_size != mem_none)
        else begin
            fail_count++;
            $error("store decoded without a memory size");
        end

endmodule

bind idu_top idu_chk chk_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .stall_i     (stall_i),
    .dec_valid_o (dec_valid_o),
    .dec_o       (dec_o)
);

`default_nettype wire

// ==== dv/idu_tb.sv ====
`default_nettype none

module idu_tb import idu_pkg::*; ();

    localparam int NUM_GPR = 16;
    localparam int TIMEOUT = 20;

    // alu rows: func7, func3, expected operation
    localparam logic [6:0] R_F7 [10] = '{7'h00, 7'h20, 7'h00, 7'h00, 7'h00,
                                         7'h00, 7'h00, 7'h20, 7'h00, 7'h00};
    localparam logic [2:0] R_F3 [10] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3,
                                         3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
    localparam alu_op_e R_OP [10] = '{alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
                                      alu_xor, alu_srl, alu_sra, alu_or, alu_and};
    // load rows, the first three are also store sizes
    localparam logic [2:0] L_F3 [5] = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
    localparam mem_size_e L_SZ [5] = '{mem_byte, mem_half, mem_word, mem_byte_u, mem_half_u};

    logic            clk;
    logic            rst_n;
    logic            inst_valid;
    logic [XLEN-1:0] inst;
    logic [XLEN-1:0] pc;
    logic            stall;
    gpr_wb_t         wb;
    logic            dec_valid;
    decode_out_t     dec;
    int              errors;
    int              checks;
    logic [XLEN-1:0] next_pc;

    idu_top #(
        .NUM_GPR (NUM_GPR)
    ) dut_i (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .inst_valid_i (inst_valid),
        .inst_i       (inst),
        .pc_i         (pc),
        .stall_i      (stall),
        .wb_i         (wb),
        .dec_valid_o  (dec_valid),
        .dec_o        (dec)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ========================================
    // encoders and helpers
    // ========================================
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    // sign extension from bit top
    function automatic logic [31:0] sext(input logic [31:0] val, input int top);
        return $signed(val << (31 - top)) >>> (31 - top);
    endfunction

    function automatic logic [4:0] rand_reg();
        return 5'(1 + ($urandom % (NUM_GPR - 1)));
    endfunction

    function automatic logic [11:0] rand_imm12();
        return 12'($urandom);
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic drive(input logic [31:0] word, input logic [31:0] addr);
        @(posedge clk);
        inst_valid <= 1'b1;
        inst       <= word;
        pc         <= addr;
    endtask

    // pc tags each instruction, so the right bundle is recognised
    task automatic wait_pc(input logic [31:0] addr, output int cycles);
        cycles = 0;
        while (!(dec_valid && dec.pc == addr) && cycles < TIMEOUT) begin
            @(posedge clk);
            @(negedge clk);
            cycles++;
        end
        if (!(dec_valid && dec.pc == addr)) begin
            $display("timeout while waiting for the instruction at pc 0x%08h", addr);
            $display("Test failures found");
            $finish;
        end
    endtask

    task automatic issue(input logic [31:0] word, output int cycles);
        next_pc = next_pc + 32'd4;
        drive(word, next_pc);
        wait_pc(next_pc, cycles);
    endtask

    task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
        @(posedge clk);
        wb <= '{en: 1'b1, addr: addr, data: data};
        @(posedge clk);
        wb.en <= 1'b0;
    endtask

    task automatic report(input string name, input int errs_before);
        $display("%-10s done, %0d errors", name, errors - errs_before);
    endtask

    // ========================================
    // tests
    // ========================================
    task automatic test_reset();
        int e0;
        int cycles;
        e0 = errors;
        check("dec_valid_o", 32'(dec_valid), 32'd0);
        check("dec_o", 32'(dec != '0), 32'd0);
        issue(enc_i(12'd5, 5'd1, 3'b000, 5'd2, opc_op_imm), cycles);
        check("latency", 32'(cycles), 32'd1);
        report("reset", e0);
    endtask

    task automatic test_alu();
        int e0;
        int cycles;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [11:0] imm;
        e0 = errors;
        for (int k = 0; k < 10; k++) begin
            rd  = rand_reg();
            rs1 = rand_reg();
            rs2 = rand_reg();
            issue(enc_r(R_F7[k], rs2, rs1, R_F3[k], rd, opc_op), cycles);
            check("dec_o.ctrl.alu_op", 32'(dec.ctrl.alu_op), 32'(R_OP[k]));
            check("dec_o.ctrl.src1", 32'(dec.ctrl.src1), 32'(src1_rs1));
            check("dec_o.ctrl.src2", 32'(dec.ctrl.src2), 32'(src2_rs2));
            check("dec_o.ctrl.fmt", 32'(dec.ctrl.fmt), 32'(fmt_r));
            check("dec_o.rd", 32'(dec.rd), 32'(rd));
            check("dec_o.rs2", 32'(dec.rs2), 32'(rs2));
            check("dec_o.ctrl.illegal", 32'(dec.ctrl.illegal), 32'd0);
            // no immediate form of sub
            if (k != 1) begin
                if (R_F3[k] == 3'b001 || R_F3[k] == 3'b101) begin
                    imm = {R_F7[k], 5'($urandom)};
                end else begin
                    imm = rand_imm12();
                end
                issue(enc_i(imm, rs1, R_F3[k], rd, opc_op_imm), cycles);
                check("dec_o.ctrl.alu_op", 32'(dec.ctrl.alu_op), 32'(R_OP[k]));
                check("dec_o.ctrl.src2", 32'(dec.ctrl.src2), 32'(src2_imm));
                check("dec_o.ctrl.fmt", 32'(dec.ctrl.fmt), 32'(fmt_i));
                check("dec_o.imm", dec.imm, sext(32'(imm), 11));
                check("dec_o.rs1", 32'(dec.rs1), 32'(rs1));
            end
        end
        report("alu", e0);
    endtask

    task automatic test_mem();
        int e0;
        int cycles;
        logic [11:0] imm;
        e0 = errors;
        for (int k = 0; k < 5; k++) begin
            imm = rand_imm12();
            issue(enc_i(imm, rand_reg(), L_F3[k], rand_reg(), opc_load), cycles);
            check("dec_o.ctrl.mem_size", 32'(dec.ctrl.mem_size), 32'(L_SZ[k]));
            check("dec_o.ctrl.mem_to_reg", 32'(dec.ctrl.mem_to_reg), 32'd1);
            check("dec_o.ctrl.write_mem", 32'(dec.ctrl.write_mem), 32'd0);
            check("dec_o.ctrl.write_gpr", 32'(dec.ctrl.write_gpr), 32'd1);
            check("dec_o.imm", dec.imm, sext(32'(imm), 11));
            if (k < 3) begin
                imm = rand_imm12();
                issue(enc_s(imm, rand_reg(), rand_reg(), L_F3[k]), cycles);
                check("dec_o.ctrl.mem_size", 32'(dec.ctrl.mem_size), 32'(L_SZ[k]));
                check("dec_o.ctrl.mem_to_reg", 32'(dec.ctrl.mem_to_reg), 32'd0);
                check("dec_o.ctrl.write_mem", 32'(dec.ctrl.write_mem), 32'd1);
                check("dec_o.ctrl.write_gpr", 32'(dec.ctrl.write_gpr), 32'd0);
                check("dec_o.imm", dec.imm, sext(32'(imm), 11));
            end
        end
        report("mem", e0);
    endtask

    task automatic test_flow();
        int e0;
        int cycles;
        logic [2:0] f3;
        logic [12:0] boff;
        logic [20:0] joff;
        logic [11:0] imm;
        logic [31:0] up;
        e0 = errors;
        // beq, bne, blt, bge, bltu, bgeu
        for (int k = 0; k < 6; k++) begin
            f3 = (k < 2) ? 3'(k) : 3'(k + 2);
            boff = {12'($urandom), 1'b0};
            issue(enc_b(boff, rand_reg(), rand_reg(), f3), cycles);
            check("dec_o.ctrl.is_branch", 32'(dec.ctrl.is_branch), 32'd1);
            check("dec_o.ctrl.jump_kind", 32'(dec.ctrl.jump_kind), 32'(jmp_none));
            check("dec_o.ctrl.src1", 32'(dec.ctrl.src1), 32'(src1_rs1));
            check("dec_o.ctrl.src2", 32'(dec.ctrl.src2), 32'(src2_rs2));
            check("dec_o.ctrl.write_gpr", 32'(dec.ctrl.write_gpr), 32'd0);
            check("dec_o.imm", dec.imm, sext(32'(boff), 12));
        end
        joff = {20'($urandom), 1'b0};
        issue(enc_j(joff, rand_reg()), cycles);
        check("dec_o.ctrl.jump_kind", 32'(dec.ctrl.jump_kind), 32'(jmp_pc_imm));
        check("dec_o.ctrl.src1", 32'(dec.ctrl.src1), 32'(src1_pc));
        check("dec_o.ctrl.src2", 32'(dec.ctrl.src2), 32'(src2_four));
        check("dec_o.ctrl.write_gpr", 32'(dec.ctrl.write_gpr), 32'd1);
        check("dec_o.imm", dec.imm, sext(32'(joff), 20));
        imm = rand_imm12();
        issue(enc_i(imm, rand_reg(), 3'b000, rand_reg(), opc_jalr), cycles);
        check("dec_o.ctrl.jump_kind", 32'(dec.ctrl.jump_kind), 32'(jmp_rs1_imm));
        check("dec_o.ctrl.src1", 32'(dec.ctrl.src1), 32'(src1_rs1));
        check("dec_o.ctrl.src2", 32'(dec.ctrl.src2), 32'(src2_four));
        check("dec_o.imm", dec.imm, sext(32'(imm), 11));
        // lui and auipc share the upper immediate
        up = {20'($urandom), 12'h000};
        issue({up[31:12], rand_reg(), opc_lui}, cycles);
        check("dec_o.ctrl.alu_op", 32'(dec.ctrl.alu_op), 32'(alu_pass));
        check("dec_o.ctrl.write_gpr", 32'(dec.ctrl.write_gpr), 32'd1);
        check("dec_o.imm", dec.imm, up);
        issue({up[31:12], rand_reg(), opc_auipc}, cycles);
        check("dec_o.ctrl.src1", 32'(dec.ctrl.src1), 32'(src1_pc));
        check("dec_o.imm", dec.imm, up);
        // csrrw then csrrs
        for (int k = 1; k < 3; k++) begin
            imm = rand_imm12();
            issue(enc_i(imm, rand_reg(), 3'(k), rand_reg(), opc_system), cycles);
            check("dec_o.ctrl.alu_op", 32'(dec.ctrl.alu_op), 32'(alu_pass));
            check("dec_o.ctrl.src2", 32'(dec.ctrl.src2), 32'(src2_csr));
            check("dec_o.ctrl.write_csr", 32'(dec.ctrl.write_csr), 32'd1);
            check("dec_o.ctrl.write_gpr", 32'(dec.ctrl.write_gpr), 32'd1);
            check("dec_o.ctrl.csr_id", 32'(dec.ctrl.csr_id), 32'(imm));
        end
        issue(32'h0000_0073, cycles);
        check("dec_o.ctrl.jump_kind", 32'(dec.ctrl.jump_kind), 32'(jmp_csr));
        check("dec_o.ctrl.halt", 32'(dec.ctrl.halt), 32'd0);
        issue(32'h3020_0073, cycles);
        check("dec_o.ctrl.jump_kind", 32'(dec.ctrl.jump_kind), 32'(jmp_csr));
        check("dec_o.ctrl.write_gpr", 32'(dec.ctrl.write_gpr), 32'd0);
        issue(32'h0010_0073, cycles);
        check("dec_o.ctrl.halt", 32'(dec.ctrl.halt), 32'd1);
        check("dec_o.ctrl.jump_kind", 32'(dec.ctrl.jump_kind), 32'(jmp_none));
        report("flow", e0);
    endtask

    task automatic test_gpr();
        int e0;
        int cycles;
        logic [31:0] d5;
        logic [31:0] d6;
        logic [31:0] d9;
        e0 = errors;
        d5 = $urandom;
        d6 = $urandom;
        d9 = $urandom | 32'h1;
        write_reg(5'd5, d5);
        write_reg(5'd6, d6);
        issue(enc_r(7'h00, 5'd6, 5'd5, 3'b000, 5'd7, opc_op), cycles);
        check("dec_o.rs1_data", dec.rs1_data, d5);
        check("dec_o.rs2_data", dec.rs2_data, d6);
        write_reg(5'd0, 32'hdead_beef);
        issue(enc_r(7'h00, 5'd5, 5'd0, 3'b000, 5'd7, opc_op), cycles);
        check("dec_o.rs1_data", dec.rs1_data, 32'd0);
        // write and read of x9 at the same edge
        next_pc = next_pc + 32'd4;
        drive(enc_r(7'h00, 5'd9, 5'd9, 3'b000, 5'd3, opc_op), next_pc);
        wb <= '{en: 1'b1, addr: 5'd9, data: d9};
        wait_pc(next_pc, cycles);
        check("dec_o.rs1_data", dec.rs1_data, d9);
        check("dec_o.rs2_data", dec.rs2_data, d9);
        @(posedge clk);
        wb.en <= 1'b0;
        report("gpr", e0);
    endtask

    task automatic test_stall();
        int e0;
        int cycles;
        logic [31:0] held;
        e0 = errors;
        issue(enc_i(12'd1, 5'd1, 3'b000, 5'd4, opc_op_imm), cycles);
        held = next_pc;
        next_pc = next_pc + 32'd4;
        @(posedge clk);
        stall <= 1'b1;
        inst  <= enc_i(12'd2, 5'd2, 3'b000, 5'd8, opc_op_imm);
        pc    <= next_pc;
        for (int k = 0; k < 3; k++) begin
            @(negedge clk);
            check("dec_o.pc", dec.pc, held);
            check("dec_o.rd", 32'(dec.rd), 32'd4);
            check("dec_valid_o", 32'(dec_valid), 32'd1);
        end
        @(posedge clk);
        stall <= 1'b0;
        wait_pc(next_pc, cycles);
        check("latency", 32'(cycles), 32'd1);
        check("dec_o.rd", 32'(dec.rd), 32'd8);
        issue(32'h0000_007f, cycles);
        check("dec_o.ctrl.illegal", 32'(dec.ctrl.illegal), 32'd1);
        // x16 is outside RV32E
        issue(enc_i(12'd0, 5'd1, 3'b000, 5'd16, opc_op_imm), cycles);
        check("dec_o.ctrl.illegal", 32'(dec.ctrl.illegal), 32'd1);
        check("dec_o.ctrl.write_gpr", 32'(dec.ctrl.write_gpr), 32'd0);
        report("stall", e0);
    endtask

    // ========================================
    // main sequence
    // ========================================
    initial begin
        void'($urandom(32'ha2a5_f120));
        errors     = 0;
        checks     = 0;
        next_pc    = 32'h0000_1000;
        rst_n      = 1'b0;
        inst_valid = 1'b0;
        inst       = '0;
        pc         = '0;
        stall      = 1'b0;
        wb         = '0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        test_reset();
        test_alu();
        test_mem();
        test_flow();
        test_gpr();
        test_stall();
        errors = errors + dut_i.chk_i.fail_count;
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
source/idu_pkg.sv
source/idu_decode.sv
source/idu_imm_gen.sv
source/idu_gpr_file.sv
source/idu_top.sv
dv/idu_chk.sv
dv/idu_tb.sv

// ==== Makefile ====
TOOL  := verilator
FLAGS := --binary --timing --assert -j 0
TOP   := idu_tb
FLIST := flist.f
BUILD := obj_dir
LOG   := sim.log
PASS  := All tests passed!

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
